// File: include/rob_defs_defs.svh
`ifndef ROB_DEFS_DEFS_SVH
`define ROB_DEFS_DEFS_SVH

// ------------------------------------------------------------
// reorder buffer sizing
// ------------------------------------------------------------

// number of reorder entries
`define ROB_ENTRIES 8

// index bits of an entry, log2 of ROB_ENTRIES
`define ROB_ENTRY_W 3

// commit id is the entry index plus a wrap bit
`define ROB_CMT_ID_W 4

// instructions in one dispatch group
`define ROB_DISP_SIZE 2

// completion report ports from the execution units
`define ROB_DONE_PORTS 2

// floating-point exception flags
`define ROB_FFLAGS_W 5

`endif

// File: src/rob_pkg.sv
`default_nettype none

`include "rob_defs_defs.svh"

package rob_pkg;

  // index in the low bits, wrap bit on top
  typedef logic [`ROB_CMT_ID_W-1:0] cmt_id_t;

  // one bit per slot of a dispatch group
  typedef logic [`ROB_DISP_SIZE-1:0] grp_id_t;

  typedef logic [`ROB_FFLAGS_W-1:0] fflags_t;

  // payload of one completion report
  typedef struct packed {
    logic    except_valid;
    logic    fflags_update_valid;
    fflags_t fflags;
  } done_rpt_t;

  typedef struct packed {
    logic                           valid;
    logic                           cmt_id_msb;   // wrap bit at dispatch
    grp_id_t                        grp_id;       // occupied slots
    grp_id_t                        done_grp_id;  // slots reported done
    grp_id_t                        dead;         // slots that will not retire
    grp_id_t                        except;       // slots with an exception
    fflags_t [`ROB_DISP_SIZE-1:0]   fflags;       // zero unless update was reported
  } rob_entry_t;

  // true when slot a_grp of group a_id is younger than slot b_grp of b_id
  function automatic logic is_younger(cmt_id_t a_id, grp_id_t a_grp,
                                      cmt_id_t b_id, grp_id_t b_grp);
    cmt_id_t diff;
    diff = a_id - b_id;  // wraps modulo 16
    if (a_id == b_id) begin
      return a_grp > b_grp;  // one-hot masks compare like indices
    end
    return (diff != '0) && (diff <= `ROB_ENTRIES);
  endfunction

endpackage

`default_nettype wire

// File: src/rob_if.sv
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------
// completion report from one execution port
// ------------------------------------------------------------
interface done_report_if;
  logic              valid;
  rob_pkg::cmt_id_t  cmt_id;
  rob_pkg::grp_id_t  grp_id;  // exactly one slot
  logic              except_valid;
  logic              fflags_update_valid;
  rob_pkg::fflags_t  fflags;

  modport master (output valid, cmt_id, grp_id, except_valid, fflags_update_valid, fflags);
  modport slave  (input  valid, cmt_id, grp_id, except_valid, fflags_update_valid, fflags);
endinterface

// ------------------------------------------------------------
// branch resolution
// ------------------------------------------------------------
interface br_upd_if;
  logic              update;
  rob_pkg::cmt_id_t  cmt_id;
  rob_pkg::grp_id_t  grp_id;  // slot of the branch
  logic              mispredict;

  modport master (output update, cmt_id, grp_id, mispredict);
  modport slave  (input  update, cmt_id, grp_id, mispredict);
endinterface

`default_nettype wire

// File: src/onehot_mux.sv
`timescale 1ns/1ps
`default_nettype none

// OR of every word whose select bit is set
module onehot_mux #(
  parameter type T     = logic,
  parameter int  WORDS = 2
) (
  input  logic [WORDS-1:0] i_sel,
  input  T                 i_data [WORDS],
  output T                 o_data
);

  always_comb begin
    o_data = T'('0);
    for (int w = 0; w < WORDS; w++) begin
      if (i_sel[w]) begin
        o_data = T'(o_data | i_data[w]);  // select is one-hot, so OR picks the word
      end
    end
  end

endmodule

`default_nettype wire

// File: src/rob_alloc.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs_defs.svh"

module rob_alloc (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_disp_valid,
  input  rob_pkg::grp_id_t         i_disp_grp_id,
  input  logic                     i_commit,
  input  logic                     i_flush,
  output logic [`ROB_ENTRIES-1:0]  o_load,
  output rob_pkg::rob_entry_t      o_entry_in,
  output rob_pkg::cmt_id_t         o_cmt_id,
  output logic                     o_full
);

  rob_pkg::cmt_id_t        r_tail;   // next id to hand out
  logic [`ROB_ENTRY_W:0]   r_count;  // entries in use, 0..8
  logic                    w_accept;

  assign o_full   = (r_count == `ROB_ENTRIES);
  assign w_accept = i_disp_valid & ~o_full;
  assign o_cmt_id = r_tail;

  // one-hot load strobe for the tail entry
  always_comb begin
    for (int e = 0; e < `ROB_ENTRIES; e++) begin
      o_load[e] = w_accept && (r_tail[`ROB_ENTRY_W-1:0] == e[`ROB_ENTRY_W-1:0]);
    end
  end

  always_comb begin
    o_entry_in            = '0;
    o_entry_in.valid      = 1'b1;
    o_entry_in.cmt_id_msb = r_tail[`ROB_CMT_ID_W-1];
    o_entry_in.grp_id     = i_disp_grp_id;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail  <= '0;
      r_count <= '0;
    end else if (i_flush) begin
      r_tail  <= '0;  // every entry is cleared on this edge
      r_count <= '0;
    end else begin
      if (w_accept) begin
        r_tail <= r_tail + 1'b1;  // carry into the msb flips the wrap bit
      end
      case ({w_accept, i_commit})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/rob_entry.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs_defs.svh"

module rob_entry (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic [`ROB_ENTRY_W-1:0]  i_index_id,
  input  logic                     i_load_valid,
  input  rob_pkg::rob_entry_t      i_entry_in,
  done_report_if.slave             done_if [`ROB_DONE_PORTS],
  br_upd_if.slave                  br_if,
  input  logic                     i_kill,
  input  logic                     i_commit_finish,
  output rob_pkg::rob_entry_t      o_entry,
  output logic                     o_block_all_done
);

  rob_pkg::rob_entry_t                      r_entry;
  rob_pkg::rob_entry_t                      w_entry_next;
  rob_pkg::cmt_id_t                         w_cmt_id;     // id of the stored group
  rob_pkg::cmt_id_t                         w_in_cmt_id;  // id of a group being loaded
  rob_pkg::grp_id_t                         w_rpt_valid;
  rob_pkg::grp_id_t                         w_rpt_except;
  rob_pkg::fflags_t [`ROB_DISP_SIZE-1:0]    w_rpt_fflags;
  rob_pkg::grp_id_t                         w_exc_hit;
  rob_pkg::grp_id_t                         w_kill_later;
  rob_pkg::grp_id_t                         w_finished;

  assign w_cmt_id    = {r_entry.cmt_id_msb, i_index_id};
  assign w_in_cmt_id = {i_entry_in.cmt_id_msb, i_index_id};

  // ------------------------------------------------------------
  // report match, one payload mux per slot
  // ------------------------------------------------------------
  for (genvar d = 0; d < `ROB_DISP_SIZE; d++) begin : g_slot
    logic [`ROB_DONE_PORTS-1:0] w_hit;
    rob_pkg::done_rpt_t         w_payload [`ROB_DONE_PORTS];
    rob_pkg::done_rpt_t         w_sel;

    for (genvar p = 0; p < `ROB_DONE_PORTS; p++) begin : g_port
      assign w_hit[p] = done_if[p].valid &&
                        (done_if[p].cmt_id[`ROB_ENTRY_W-1:0] == i_index_id) &&
                        (done_if[p].grp_id == rob_pkg::grp_id_t'(1 << d));
      assign w_payload[p] = {done_if[p].except_valid,
                             done_if[p].fflags_update_valid,
                             done_if[p].fflags};
    end

    onehot_mux #(
      .T     (rob_pkg::done_rpt_t),
      .WORDS (`ROB_DONE_PORTS)
    ) u_rpt_mux (
      .i_sel  (w_hit),
      .i_data (w_payload),
      .o_data (w_sel)
    );

    assign w_rpt_valid[d]  = |w_hit;
    assign w_rpt_except[d] = w_sel.except_valid;
    assign w_rpt_fflags[d] = w_sel.fflags_update_valid ? w_sel.fflags : '0;
  end

  // an exception in slot k kills every slot above k
  assign w_exc_hit = w_rpt_valid & w_rpt_except & ~r_entry.dead;

  always_comb begin
    w_kill_later[0] = 1'b0;
    for (int d = 1; d < `ROB_DISP_SIZE; d++) begin
      w_kill_later[d] = w_kill_later[d-1] | w_exc_hit[d-1];
    end
  end

  // ------------------------------------------------------------
  // next state
  // ------------------------------------------------------------
  always_comb begin
    w_entry_next = r_entry;

    if (i_load_valid) begin
      w_entry_next = i_entry_in;
      // branch resolving in the load cycle still sees the new group
      for (int d = 0; d < `ROB_DISP_SIZE; d++) begin
        if (br_if.update && br_if.mispredict && i_entry_in.grp_id[d] &&
            rob_pkg::is_younger(w_in_cmt_id, rob_pkg::grp_id_t'(1 << d),
                                br_if.cmt_id, br_if.grp_id)) begin
          w_entry_next.done_grp_id[d] = 1'b1;
          w_entry_next.dead[d]        = 1'b1;
        end
      end
    end else if (r_entry.valid) begin
      w_entry_next.done_grp_id = r_entry.done_grp_id | w_rpt_valid;

      for (int d = 0; d < `ROB_DISP_SIZE; d++) begin
        if (w_rpt_valid[d] && !r_entry.dead[d]) begin
          w_entry_next.except[d] = w_rpt_except[d];
          w_entry_next.fflags[d] = w_rpt_fflags[d];  // dead slot keeps old flags
        end
        if (w_kill_later[d] && r_entry.grp_id[d]) begin
          w_entry_next.dead[d] = 1'b1;
        end
        if (br_if.update && br_if.mispredict && r_entry.grp_id[d] &&
            rob_pkg::is_younger(w_cmt_id, rob_pkg::grp_id_t'(1 << d),
                                br_if.cmt_id, br_if.grp_id)) begin
          w_entry_next.done_grp_id[d] = 1'b1;
          w_entry_next.dead[d]        = 1'b1;
        end
      end

      if (i_commit_finish) begin
        w_entry_next.valid = 1'b0;  // retired
      end
    end

    if (i_kill) begin
      w_entry_next = '0;  // flush drops everything, a same-cycle load too
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_entry <= '0;
    end else begin
      r_entry <= w_entry_next;
    end
  end

  assign w_finished       = (r_entry.done_grp_id | r_entry.dead) & r_entry.grp_id;
  assign o_entry          = r_entry;
  assign o_block_all_done = r_entry.valid & (w_finished == r_entry.grp_id);

endmodule

`default_nettype wire

// File: src/rob_commit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs_defs.svh"

module rob_commit (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  rob_pkg::rob_entry_t      i_entries [`ROB_ENTRIES],
  input  logic [`ROB_ENTRIES-1:0]  i_all_done,
  output logic [`ROB_ENTRIES-1:0]  o_commit_finish,
  output logic                     o_commit_valid,
  output rob_pkg::cmt_id_t         o_commit_cmt_id,
  output rob_pkg::grp_id_t         o_commit_grp_id,
  output rob_pkg::grp_id_t         o_commit_dead,
  output logic                     o_commit_except,
  output rob_pkg::fflags_t         o_commit_fflags,
  output logic                     o_flush
);

  logic [`ROB_ENTRIES-1:0]  r_head_oh;   // one-hot head entry
  logic                     r_head_msb;  // wrap bit of the head
  logic [`ROB_ENTRY_W-1:0]  w_head_idx;
  rob_pkg::rob_entry_t      w_head;
  rob_pkg::grp_id_t         w_live;
  rob_pkg::grp_id_t         w_first_live;

  onehot_mux #(
    .T     (rob_pkg::rob_entry_t),
    .WORDS (`ROB_ENTRIES)
  ) u_head_mux (
    .i_sel  (r_head_oh),
    .i_data (i_entries),
    .o_data (w_head)
  );

  always_comb begin
    w_head_idx = '0;
    for (int e = 0; e < `ROB_ENTRIES; e++) begin
      if (r_head_oh[e]) begin
        w_head_idx = w_head_idx | e[`ROB_ENTRY_W-1:0];
      end
    end
  end

  // ------------------------------------------------------------
  // retire the head group
  // ------------------------------------------------------------
  assign w_live       = w_head.grp_id & ~w_head.dead;
  assign w_first_live = w_live & (~w_live + 1'b1);  // lowest live slot

  assign o_commit_valid  = |(r_head_oh & i_all_done);
  assign o_commit_finish = o_commit_valid ? r_head_oh : '0;
  assign o_commit_cmt_id = {r_head_msb, w_head_idx};
  assign o_commit_grp_id = w_live;
  assign o_commit_dead   = w_head.dead & w_head.grp_id;
  assign o_commit_except = |(w_first_live & w_head.except);
  assign o_flush         = o_commit_valid & o_commit_except;

  always_comb begin
    o_commit_fflags = '0;
    for (int d = 0; d < `ROB_DISP_SIZE; d++) begin
      if (w_live[d]) begin
        o_commit_fflags = o_commit_fflags | w_head.fflags[d];
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head_oh  <= `ROB_ENTRIES'(1);
      r_head_msb <= 1'b0;
    end else if (o_flush) begin
      r_head_oh  <= `ROB_ENTRIES'(1);  // back to entry 0 with the tail
      r_head_msb <= 1'b0;
    end else if (o_commit_valid) begin
      r_head_oh <= {r_head_oh[`ROB_ENTRIES-2:0], r_head_oh[`ROB_ENTRIES-1]};
      if (r_head_oh[`ROB_ENTRIES-1]) begin
        r_head_msb <= ~r_head_msb;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs_defs.svh"

module rob_top (
  input  logic                                          i_clk,
  input  logic                                          i_reset_n,
  // dispatch
  input  logic                                          i_disp_valid,
  input  rob_pkg::grp_id_t                              i_disp_grp_id,
  output rob_pkg::cmt_id_t                              o_disp_cmt_id,
  output logic                                          o_full,
  // completion reports, one element per port
  input  logic [`ROB_DONE_PORTS-1:0]                    i_rpt_valid,
  input  rob_pkg::cmt_id_t [`ROB_DONE_PORTS-1:0]        i_rpt_cmt_id,
  input  rob_pkg::grp_id_t [`ROB_DONE_PORTS-1:0]        i_rpt_grp_id,
  input  logic [`ROB_DONE_PORTS-1:0]                    i_rpt_except,
  input  logic [`ROB_DONE_PORTS-1:0]                    i_rpt_fflags_upd,
  input  rob_pkg::fflags_t [`ROB_DONE_PORTS-1:0]        i_rpt_fflags,
  // branch update
  input  logic                                          i_br_update,
  input  rob_pkg::cmt_id_t                              i_br_cmt_id,
  input  rob_pkg::grp_id_t                              i_br_grp_id,
  input  logic                                          i_br_mispredict,
  // commit
  output logic                                          o_commit_valid,
  output rob_pkg::cmt_id_t                              o_commit_cmt_id,
  output rob_pkg::grp_id_t                              o_commit_grp_id,
  output rob_pkg::grp_id_t                              o_commit_dead,
  output logic                                          o_commit_except,
  output rob_pkg::fflags_t                              o_commit_fflags,
  output logic                                          o_flush
);

  logic [`ROB_ENTRIES-1:0]  w_load;
  rob_pkg::rob_entry_t      w_entry_in;
  rob_pkg::rob_entry_t      w_entries [`ROB_ENTRIES];
  logic [`ROB_ENTRIES-1:0]  w_all_done;
  logic [`ROB_ENTRIES-1:0]  w_commit_finish;

  // ------------------------------------------------------------
  // port bundles
  // ------------------------------------------------------------
  done_report_if u_done_if [`ROB_DONE_PORTS] ();
  br_upd_if      u_br_if ();

  for (genvar p = 0; p < `ROB_DONE_PORTS; p++) begin : g_rpt
    assign u_done_if[p].valid               = i_rpt_valid[p];
    assign u_done_if[p].cmt_id              = i_rpt_cmt_id[p];
    assign u_done_if[p].grp_id              = i_rpt_grp_id[p];
    assign u_done_if[p].except_valid        = i_rpt_except[p];
    assign u_done_if[p].fflags_update_valid = i_rpt_fflags_upd[p];
    assign u_done_if[p].fflags              = i_rpt_fflags[p];
  end

  assign u_br_if.update     = i_br_update;
  assign u_br_if.cmt_id     = i_br_cmt_id;
  assign u_br_if.grp_id     = i_br_grp_id;
  assign u_br_if.mispredict = i_br_mispredict;

  rob_alloc u_alloc (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_valid  (i_disp_valid),
    .i_disp_grp_id (i_disp_grp_id),
    .i_commit      (o_commit_valid),
    .i_flush       (o_flush),
    .o_load        (w_load),
    .o_entry_in    (w_entry_in),
    .o_cmt_id      (o_disp_cmt_id),
    .o_full        (o_full)
  );

  for (genvar e = 0; e < `ROB_ENTRIES; e++) begin : g_entry
    localparam logic [`ROB_ENTRY_W-1:0] INDEX = e;

    rob_entry u_entry (
      .i_clk            (i_clk),
      .i_reset_n        (i_reset_n),
      .i_index_id       (INDEX),
      .i_load_valid     (w_load[e]),
      .i_entry_in       (w_entry_in),
      .done_if          (u_done_if),
      .br_if            (u_br_if),
      .i_kill           (o_flush),
      .i_commit_finish  (w_commit_finish[e]),
      .o_entry          (w_entries[e]),
      .o_block_all_done (w_all_done[e])
    );
  end

  rob_commit u_commit (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_entries       (w_entries),
    .i_all_done      (w_all_done),
    .o_commit_finish (w_commit_finish),
    .o_commit_valid  (o_commit_valid),
    .o_commit_cmt_id (o_commit_cmt_id),
    .o_commit_grp_id (o_commit_grp_id),
    .o_commit_dead   (o_commit_dead),
    .o_commit_except (o_commit_except),
    .o_commit_fflags (o_commit_fflags),
    .o_flush         (o_flush)
  );

endmodule

`default_nettype wire

// File: bench/rob_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rob_sva (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_disp_valid,
  input  logic              o_full,
  input  rob_pkg::cmt_id_t  o_disp_cmt_id,
  input  logic              o_commit_valid,
  input  logic              o_flush
);

  // a dispatch into a full buffer would overwrite the head entry
  a_no_disp_when_full : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_disp_valid && o_full))
    else $error("dispatch accepted while the reorder buffer is full");

  a_quiet_in_reset : assert property (@(posedge i_clk)
    !i_reset_n |-> (!o_commit_valid && !o_flush))
    else $error("commit or flush active during reset");

  // flush comes with an excepting commit and leaves an empty buffer at id 0
  a_flush_restarts : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_flush |-> o_commit_valid ##1 (!o_commit_valid && !o_full && o_disp_cmt_id == '0))
    else $error("flush without a commit or buffer not emptied after flush");

endmodule

bind rob_top rob_sva u_sva (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_disp_valid   (i_disp_valid),
  .o_full         (o_full),
  .o_disp_cmt_id  (o_disp_cmt_id),
  .o_commit_valid (o_commit_valid),
  .o_flush        (o_flush)
);

`default_nettype wire

// File: bench/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs_defs.svh"

module rob_tb;

  localparam int DRAIN_TIMEOUT   = 100;   // cycles
  localparam int WATCHDOG_CYCLES = 4000;

  typedef struct packed {
    rob_pkg::cmt_id_t  id;
    rob_pkg::grp_id_t  live;
    rob_pkg::grp_id_t  dead;
    logic              except;
    rob_pkg::fflags_t  fflags;
  } exp_commit_t;

  logic                                    i_clk;
  logic                                    i_reset_n;
  logic                                    i_disp_valid;
  rob_pkg::grp_id_t                        i_disp_grp_id;
  rob_pkg::cmt_id_t                        o_disp_cmt_id;
  logic                                    o_full;
  logic [`ROB_DONE_PORTS-1:0]              i_rpt_valid;
  rob_pkg::cmt_id_t [`ROB_DONE_PORTS-1:0]  i_rpt_cmt_id;
  rob_pkg::grp_id_t [`ROB_DONE_PORTS-1:0]  i_rpt_grp_id;
  logic [`ROB_DONE_PORTS-1:0]              i_rpt_except;
  logic [`ROB_DONE_PORTS-1:0]              i_rpt_fflags_upd;
  rob_pkg::fflags_t [`ROB_DONE_PORTS-1:0]  i_rpt_fflags;
  logic                                    i_br_update;
  rob_pkg::cmt_id_t                        i_br_cmt_id;
  rob_pkg::grp_id_t                        i_br_grp_id;
  logic                                    i_br_mispredict;
  logic                                    o_commit_valid;
  rob_pkg::cmt_id_t                        o_commit_cmt_id;
  rob_pkg::grp_id_t                        o_commit_grp_id;
  rob_pkg::grp_id_t                        o_commit_dead;
  logic                                    o_commit_except;
  rob_pkg::fflags_t                        o_commit_fflags;
  logic                                    o_flush;

  exp_commit_t  exp_q [$];   // commits still to come, in order
  exp_commit_t  exp_head;
  int           errors  = 0;
  int           checked = 0;
  integer       seed    = 32'h7c68_4c92;

  rob_top uut (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_bad_record(input logic [7:0] kind);
    $display("%0t: malformed %s record in the golden file", $time, kind);
    errors++;
  endtask

  task automatic clear_strobes();
    i_disp_valid = 1'b0;
    i_rpt_valid  = '0;
    i_br_update  = 1'b0;
  endtask

  task automatic init_inputs();
    clear_strobes();
    i_disp_grp_id    = '0;
    i_rpt_cmt_id     = '0;
    i_rpt_grp_id     = '0;
    i_rpt_except     = '0;
    i_rpt_fflags_upd = '0;
    i_rpt_fflags     = '0;
    i_br_cmt_id      = '0;
    i_br_grp_id      = '0;
    i_br_mispredict  = 1'b0;
  endtask

  task automatic drive_report(input logic [31:0] port, input logic [31:0] id,
                              input logic [31:0] grp, input logic [31:0] exc,
                              input logic [31:0] upd, input logic [31:0] flags);
    i_rpt_valid[port[0]]      = 1'b1;
    i_rpt_cmt_id[port[0]]     = id[`ROB_CMT_ID_W-1:0];
    i_rpt_grp_id[port[0]]     = grp[`ROB_DISP_SIZE-1:0];
    i_rpt_except[port[0]]     = exc[0];
    i_rpt_fflags_upd[port[0]] = upd[0];
    i_rpt_fflags[port[0]]     = flags[`ROB_FFLAGS_W-1:0];
  endtask

  // idle with a random extra gap, then wait for the queued commits
  task automatic run_idle(input int cycles);
    int gap;
    int waited;
    gap    = int'($unsigned($random(seed)) % 4);
    waited = 0;
    repeat (cycles + gap) @(negedge i_clk);
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge i_clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%0t: timed out waiting for %0d expected commits", $time, exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  // ------------------------------------------------------------
  // commit monitor, sampled mid-cycle
  // ------------------------------------------------------------
  always @(negedge i_clk) begin
    if (i_reset_n && o_commit_valid) begin
      if (exp_q.size() == 0) begin
        $display("%0t: commit of id %h with no expected commit left", $time,
                 o_commit_cmt_id);
        errors++;
      end else begin
        exp_head = exp_q.pop_front();
        check_value("o_commit_cmt_id", 32'(o_commit_cmt_id), 32'(exp_head.id));
        check_value("o_commit_grp_id", 32'(o_commit_grp_id), 32'(exp_head.live));
        check_value("o_commit_dead", 32'(o_commit_dead), 32'(exp_head.dead));
        check_value("o_commit_except", 32'(o_commit_except), 32'(exp_head.except));
        check_value("o_flush", 32'(o_flush), 32'(exp_head.except));  // flush follows except
        check_value("o_commit_fflags", 32'(o_commit_fflags), 32'(exp_head.fflags));
        checked++;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    errors++;
    $display("%0t: simulation watchdog expired", $time);
    $display("commits checked: %0d, errors: %0d", checked, errors);
    $display("Errors found");
    $finish;
  end

  // ------------------------------------------------------------
  // golden-driven stimulus
  // ------------------------------------------------------------
  initial begin
    integer              fd;
    integer              rc;
    logic [7:0]          tok;
    logic [8*256-1:0]    rest;
    logic [31:0]         f0, f1, f2, f3, f4, f5;
    exp_commit_t         item;

    init_inputs();
    i_reset_n = 1'b0;
    repeat (4) @(negedge i_clk);
    i_reset_n = 1'b1;

    fd = $fopen("bench/rob_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open bench/rob_golden.txt");
      errors++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        case (tok)
          "#": rc = $fgets(rest, fd);  // comment line
          "D": begin
            rc = $fscanf(fd, "%h", f0);
            if (rc != 1) begin
              report_bad_record(tok);
            end
            i_disp_valid  = 1'b1;
            i_disp_grp_id = f0[`ROB_DISP_SIZE-1:0];
          end
          "R": begin
            rc = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
            if (rc != 6) begin
              report_bad_record(tok);
            end
            drive_report(f0, f1, f2, f3, f4, f5);
          end
          "B": begin
            rc = $fscanf(fd, "%h %h %h", f0, f1, f2);
            if (rc != 3) begin
              report_bad_record(tok);
            end
            i_br_update     = 1'b1;
            i_br_cmt_id     = f0[`ROB_CMT_ID_W-1:0];
            i_br_grp_id     = f1[`ROB_DISP_SIZE-1:0];
            i_br_mispredict = f2[0];
          end
          "T": begin
            @(negedge i_clk);
            clear_strobes();
          end
          "I": begin
            rc = $fscanf(fd, "%h", f0);
            if (rc != 1) begin
              report_bad_record(tok);
            end
            run_idle(int'(f0));
          end
          "E": begin
            rc = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
            if (rc != 5) begin
              report_bad_record(tok);
            end
            item.id     = f0[`ROB_CMT_ID_W-1:0];
            item.live   = f1[`ROB_DISP_SIZE-1:0];
            item.dead   = f2[`ROB_DISP_SIZE-1:0];
            item.except = f3[0];
            item.fflags = f4[`ROB_FFLAGS_W-1:0];
            exp_q.push_back(item);
          end
          "S": begin
            rc = $fscanf(fd, "%h %h", f0, f1);
            if (rc != 2) begin
              report_bad_record(tok);
            end
            check_value("o_full", 32'(o_full), 32'(f0[0]));
            check_value("o_disp_cmt_id", 32'(o_disp_cmt_id), 32'(f1[`ROB_CMT_ID_W-1:0]));
          end
          default: begin
            $display("%0t: unknown record %s in the golden file", $time, tok);
            errors++;
          end
        endcase
      end
      $fclose(fd);
    end

    if (exp_q.size() != 0) begin
      $display("%0d expected commits never happened", exp_q.size());
      errors++;
    end
    $display("commits checked: %0d, errors: %0d", checked, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rob_lite.f
+incdir+include
src/rob_pkg.sv
src/rob_if.sv
src/onehot_mux.sv
src/rob_alloc.sv
src/rob_entry.sv
src/rob_commit.sv
src/rob_top.sv
bench/rob_sva.sv
bench/rob_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = rob_tb
FILELIST = rob_lite.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Errors found
PASS_MSG = No errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/rob_golden.txt
# records, hex fields: D mask | R port id grp exc upd flags | B id grp mispredict
# T ends a cycle | I idle cycles | E id live dead exc flags | S full disp_id
S 0 0
# in-order retire of groups finished out of order, flags accumulate
E 0 3 0 0 18  E 1 1 0 0 00  E 2 3 0 0 03
D 3 T  D 1 T  D 3 T
R 0 2 1 0 1 01  R 1 2 2 0 1 02  T
R 0 1 1 0 0 1f  T
R 0 0 2 0 1 08  T
R 1 0 1 0 1 10  T
I 2
# exception in slot 0 kills slot 1 and flushes, ids restart at 0
E 3 1 2 1 04
D 3 T
R 0 3 1 1 1 04  T
I 2
S 0 0
# mispredict at id 1 slot 0, id 3 is dispatched in the same cycle
E 0 3 0 0 01  E 1 1 2 0 02  E 2 0 3 0 00  E 3 0 1 0 00
D 3 T  D 3 T  D 3 T
D 1  B 1 1 1  T
R 0 0 1 0 1 01  R 1 0 2 0 0 00  T
R 0 1 1 0 1 02  T
R 0 2 1 0 1 1f  T
I 2
S 0 4
# fill all eight entries, then retire them across the wrap
E 4 1 0 0 00  E 5 1 0 0 00  E 6 1 0 0 00  E 7 1 0 0 00
E 8 1 0 0 00  E 9 1 0 0 00  E a 1 0 0 00  E b 1 0 0 00
D 1 T  D 1 T  D 1 T  D 1 T
D 1 T  D 1 T  D 1 T  D 1 T
S 1 c
R 0 4 1 0 0 00  R 1 5 1 0 0 00  T
R 0 6 1 0 0 00  R 1 7 1 0 0 00  T
R 0 8 1 0 0 00  R 1 9 1 0 0 00  T
R 0 a 1 0 0 00  R 1 b 1 0 0 00  T
I 2
E c 3 0 0 03
D 3 T
R 0 c 1 0 1 02  R 1 c 2 0 1 01  T
I 2
S 0 d
